/* Bender.yml */
package:
  name: memctrl

sources:
  - src/memPkg.sv
  - src/portArbiter.sv
  - src/byteSequencer.sv
  - src/responseCollector.sv
  - src/memCtrl.sv
  - target: test
    files:
      - tb/tbRamModel.sv
      - tb/tbMemCtrl.sv

/* files.f */
src/memPkg.sv
src/portArbiter.sv
src/byteSequencer.sv
src/responseCollector.sv
src/memCtrl.sv
tb/tbRamModel.sv
tb/tbMemCtrl.sv

/* src/byteSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module byteSequencer #(
    parameter int AddrWidth = memPkg::AddrWidth
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [AddrWidth-1:0]         startAddr,
    input  memPkg::accessLen             startLen,
    input  logic                         startWrite,
    input  logic [memPkg::DataWidth-1:0] startWdata,
    input  logic                         hold,
    output logic [AddrWidth-1:0]         memAddr,
    output logic                         memWr,
    output logic [memPkg::ByteWidth-1:0] memDout,
    output logic                         readIssued,
    output logic                         lastIssued
);
    import memPkg::*;

    localparam int LaneBits = $clog2(DataWidth / ByteWidth);

    logic                  active;
    logic [StageWidth-1:0] stage;
    logic                  busy;
    logic                  issue;
    logic                  lastStage;
    logic [ByteWidth-1:0]  laneByte;

    // first byte goes out in the start cycle itself
    assign busy      = start || active;
    assign issue     = busy && !hold;
    assign lastStage = (stage == StageWidth'(startLen - 1));

    // little-endian, consecutive addresses
    assign memAddr  = startAddr + AddrWidth'(stage);
    assign laneByte = startWdata[stage[LaneBits-1:0]*ByteWidth +: ByteWidth];

    assign memWr      = issue && startWrite;
    assign memDout    = memWr ? laneByte : '0;
    assign readIssued = issue && !startWrite;
    assign lastIssued = issue && lastStage;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            stage  <= '0;
        end else if (issue) begin
            if (lastStage) begin
                active <= 1'b0;
                stage  <= '0;
            end else begin
                active <= 1'b1;
                stage  <= stage + 1'b1;
            end
        end else if (start) begin
            // start arrived during hold, keep it pending
            active <= 1'b1;
        end
    end

    // no RAM write while the pipeline is frozen
    noWriteInHold: assert property (@(posedge clk) disable iff (rst)
        hold |-> !memWr)
        else $error("memWr high during hold");

endmodule

`default_nettype wire

/* src/memCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module memCtrl #(
    parameter int AddrWidth = memPkg::AddrWidth
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         ioBufferFull,
    // instruction fetch
    input  logic                         fetchEn,
    input  logic [AddrWidth-1:0]         fetchAddr,
    output logic                         fetchDone,
    output logic [memPkg::DataWidth-1:0] fetchInst,
    // data unit
    input  logic                         dataEn,
    input  memPkg::memOp                 dataOp,
    input  memPkg::accessLen             dataLen,
    input  logic [AddrWidth-1:0]         dataAddr,
    input  logic [memPkg::DataWidth-1:0] dataWdata,
    output logic                         dataDone,
    output logic [memPkg::DataWidth-1:0] dataRdata,
    // byte RAM
    input  logic [memPkg::ByteWidth-1:0] memDin,
    output logic [AddrWidth-1:0]         memAddr,
    output logic                         memWr,
    output logic [memPkg::ByteWidth-1:0] memDout,
    output memPkg::busOwner              busOwner
);
    import memPkg::*;

    logic                 start;
    logic [AddrWidth-1:0] startAddr;
    accessLen             startLen;
    logic                 startWrite;
    logic [DataWidth-1:0] startWdata;
    logic                 hold;
    logic                 readIssued;
    logic                 lastIssued;

    portArbiter #(
        .AddrWidth(AddrWidth)
    ) uArbiter (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioBufferFull(ioBufferFull),
        .fetchEn     (fetchEn),
        .fetchAddr   (fetchAddr),
        .dataEn      (dataEn),
        .dataOp      (dataOp),
        .dataLen     (dataLen),
        .dataAddr    (dataAddr),
        .dataWdata   (dataWdata),
        .fetchDone   (fetchDone),
        .dataDone    (dataDone),
        .start       (start),
        .startAddr   (startAddr),
        .startLen    (startLen),
        .startWrite  (startWrite),
        .startWdata  (startWdata),
        .owner       (busOwner),
        .hold        (hold)
    );

    byteSequencer #(
        .AddrWidth(AddrWidth)
    ) uSequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .startAddr (startAddr),
        .startLen  (startLen),
        .startWrite(startWrite),
        .startWdata(startWdata),
        .hold      (hold),
        .memAddr   (memAddr),
        .memWr     (memWr),
        .memDout   (memDout),
        .readIssued(readIssued),
        .lastIssued(lastIssued)
    );

    // owner steers the returned word to fetch or data
    responseCollector uCollector (
        .clk       (clk),
        .rst       (rst),
        .owner     (busOwner),
        .readIssued(readIssued),
        .lastIssued(lastIssued),
        .memDin    (memDin),
        .startWrite(startWrite),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

endmodule

`default_nettype wire

/* src/memPkg.sv */
`default_nettype none

package memPkg;

    // bus widths
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;
    localparam int ByteWidth = 8;

    // counts 0 to 4
    localparam int StageWidth = 3;

    // bytes per instruction
    localparam int FetchBytes = 4;

    // access size, value is the byte count
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } memOp;

    // who holds the RAM port
    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerData  = 2'd1,
        ownerFetch = 2'd2
    } busOwner;

endpackage

`default_nettype wire

/* src/portArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module portArbiter #(
    parameter int AddrWidth = memPkg::AddrWidth
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         ioBufferFull,
    input  logic                         fetchEn,
    input  logic [AddrWidth-1:0]         fetchAddr,
    input  logic                         dataEn,
    input  memPkg::memOp                 dataOp,
    input  memPkg::accessLen             dataLen,
    input  logic [AddrWidth-1:0]         dataAddr,
    input  logic [memPkg::DataWidth-1:0] dataWdata,
    input  logic                         fetchDone,
    input  logic                         dataDone,
    output logic                         start,
    output logic [AddrWidth-1:0]         startAddr,
    output memPkg::accessLen             startLen,
    output logic                         startWrite,
    output logic [memPkg::DataWidth-1:0] startWdata,
    output memPkg::busOwner              owner,
    output logic                         hold
);
    import memPkg::*;

    logic idle;
    logic grant;
    logic doneSeen;

    // pipeline stall or full I/O buffer freezes all progress
    assign hold = !rdy || ioBufferFull;

    assign idle  = (owner == ownerNone);
    assign grant = idle && !hold && (dataEn || fetchEn);

    // only the owner's own strobe releases the port
    assign doneSeen = (owner == ownerData && dataDone) ||
                      (owner == ownerFetch && fetchDone);

    always_ff @(posedge clk) begin
        if (rst) begin
            owner      <= ownerNone;
            start      <= 1'b0;
            startAddr  <= '0;
            startLen   <= lenByte;
            startWrite <= 1'b0;
        end else begin
            start <= grant;
            if (grant) begin
                // data side wins when both wait
                if (dataEn) begin
                    owner      <= ownerData;
                    startAddr  <= dataAddr;
                    startLen   <= dataLen;
                    startWrite <= (dataOp == opStore);
                end else begin
                    owner      <= ownerFetch;
                    startAddr  <= fetchAddr;
                    startLen   <= accessLen'(FetchBytes);
                    startWrite <= 1'b0;
                end
            end else if (doneSeen) begin
                owner <= ownerNone;
            end
        end
    end

    // store data taken with the data grant
    always_ff @(posedge clk) begin
        if (grant && dataEn) begin
            startWdata <= dataWdata;
        end
    end

    // handover between requesters always passes through none
    ownerHandover: assert property (@(posedge clk) disable iff (rst)
        (owner != ownerNone) |=> (owner == $past(owner)) || (owner == ownerNone))
        else $error("owner switched requesters without release");

endmodule

`default_nettype wire

/* src/responseCollector.sv */
`timescale 1ns/10ps
`default_nettype none

module responseCollector (
    input  logic                         clk,
    input  logic                         rst,
    input  memPkg::busOwner              owner,
    input  logic                         readIssued,
    input  logic                         lastIssued,
    input  logic [memPkg::ByteWidth-1:0] memDin,
    input  logic                         startWrite,
    output logic                         fetchDone,
    output logic [memPkg::DataWidth-1:0] fetchInst,
    output logic                         dataDone,
    output logic [memPkg::DataWidth-1:0] dataRdata
);
    import memPkg::*;

    localparam int LaneBits = $clog2(DataWidth / ByteWidth);

    logic                 pendRead;
    logic                 pendLast;
    logic [LaneBits-1:0]  byteCnt;
    logic [DataWidth-1:0] word;
    logic [DataWidth-1:0] nextWord;
    logic                 writeLast;

    assign writeLast = lastIssued && startWrite;

    // first byte clears the upper lanes, so loads come out zero-extended
    always_comb begin
        nextWord = (byteCnt == '0) ? '0 : word;
        nextWord[byteCnt*ByteWidth +: ByteWidth] = memDin;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pendRead  <= 1'b0;
            pendLast  <= 1'b0;
            byteCnt   <= '0;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else begin
            // RAM answers one cycle after the address
            pendRead  <= readIssued;
            pendLast  <= readIssued && lastIssued;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
            if (pendRead) begin
                byteCnt <= pendLast ? '0 : byteCnt + 1'b1;
            end
            if (pendLast) begin
                fetchDone <= (owner == ownerFetch);
                dataDone  <= (owner == ownerData);
            end else if (writeLast) begin
                // store done right after its final byte
                dataDone <= (owner == ownerData);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pendRead) begin
            word <= nextWord;
        end
        if (pendLast && owner == ownerFetch) begin
            fetchInst <= nextWord;
        end
        if (pendLast && owner == ownerData) begin
            dataRdata <= nextWord;
        end
    end

    // one strobe per transfer
    singleDone: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone))
        else $error("fetchDone and dataDone high together");

endmodule

`default_nettype wire

/* tb/tbMemCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tbMemCtrl;
    import memPkg::*;

    localparam int AddrWidth   = 32;
    localparam int ClkPeriod   = 20;
    localparam int NumFetch    = 4;
    localparam int LoadsPerLen = 2;
    localparam int NumHold     = 12;
    // fetches, loads, stores with read back, two pairs, hold run
    localparam int NumXfer = NumFetch + 3 * LoadsPerLen + 6 + 4 + NumHold;
    // a fetch needs 8 cycles with its gap, times 6 for random hold
    localparam int TimeoutCycles = 50 + NumXfer * 8 * 6;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 rdy;
    logic                 ioBufferFull;
    logic                 fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [DataWidth-1:0] fetchInst;
    logic                 dataEn;
    memOp                 dataOp;
    accessLen             dataLen;
    logic [AddrWidth-1:0] dataAddr;
    logic [DataWidth-1:0] dataWdata;
    logic                 dataDone;
    logic [DataWidth-1:0] dataRdata;
    logic [ByteWidth-1:0] memDin;
    logic [AddrWidth-1:0] memAddr;
    logic                 memWr;
    logic [ByteWidth-1:0] memDout;
    memPkg::busOwner      busOwner;

    logic                 refWe;
    logic [AddrWidth-1:0] refAddr;
    logic [2:0]           refLen;
    logic [DataWidth-1:0] refData;
    int                   diffCount;

    logic                 firstReq = 1'b0;
    logic                 holdRun = 1'b0;
    logic                 timed = 1'b1;
    logic                 expLoad = 1'b0;
    logic [DataWidth-1:0] expData = '0;
    logic [DataWidth-1:0] expInst = '0;
    int                   expLat;
    int                   reqCyc;
    int                   errCount;
    int                   errMark;
    int                   testCount;
    int                   xferCount;

    memCtrl #(.AddrWidth(AddrWidth)) i_dut (.*);

    tbRamModel #(.AddrWidth(AddrWidth)) ram (.*);

    always #(ClkPeriod / 2) clk = ~clk;

    // cycles since the current request was raised
    always @(posedge clk) begin
        reqCyc <= (dataEn || fetchEn) ? reqCyc + 1 : 0;
    end

    idleAfterReset: assert property (@(posedge clk) disable iff (rst)
        !firstReq |-> !memWr && !fetchDone && !dataDone && busOwner == ownerNone)
        else begin
            $display("outputs active after reset before any request at %0t", $time);
            errCount++;
        end

    fetchValue: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> fetchInst == expInst)
        else begin
            $display("MISMATCH at %0t: fetchInst expected %h, actual %h",
                     $time, $sampled(expInst), $sampled(fetchInst));
            errCount++;
        end

    loadValue: assert property (@(posedge clk) disable iff (rst)
        dataDone && expLoad |-> dataRdata == expData)
        else begin
            $display("MISMATCH at %0t: dataRdata expected %h, actual %h",
                     $time, $sampled(expData), $sampled(dataRdata));
            errCount++;
        end

    doneLatency: assert property (@(posedge clk) disable iff (rst)
        (fetchDone || dataDone) && timed |-> reqCyc == expLat)
        else begin
            $display("MISMATCH at %0t: done cycle expected %0d, actual %0d",
                     $time, $sampled(expLat), $sampled(reqCyc));
            errCount++;
        end

    memImage: assert property (@(posedge clk) disable iff (rst)
        fetchDone || dataDone |-> diffCount == 0)
        else begin
            $display("MISMATCH at %0t: diffCount expected 0, actual %0d",
                     $time, $sampled(diffCount));
            errCount++;
        end

    noWriteInHold: assert property (@(posedge clk) disable iff (rst)
        !rdy || ioBufferFull |-> !memWr)
        else begin
            $display("RAM write issued during hold at %0t", $time);
            errCount++;
        end

    dataFirst: assert property (@(posedge clk) disable iff (rst)
        busOwner == ownerNone && dataEn && fetchEn && rdy && !ioBufferFull
        |=> busOwner == ownerData)
        else begin
            $display("MISMATCH at %0t: busOwner expected %0d, actual %0d",
                     $time, ownerData, $sampled(busOwner));
            errCount++;
        end

    // one clock edge, hold pattern and ref strobe follow it
    task automatic tick();
        @(posedge clk);
        refWe <= 1'b0;
        if (holdRun) begin
            rdy          <= ($urandom % 4) != 0;
            ioBufferFull <= ($urandom % 6) == 0;
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    endtask

    // little-endian, zero-extended
    function automatic logic [DataWidth-1:0] refWord(input logic [AddrWidth-1:0] addr,
                                                     input int len);
        logic [DataWidth-1:0] word;
        word = '0;
        for (int k = 0; k < len; k++) begin
            word[8*k +: 8] = ram.refMem[8'(addr + AddrWidth'(k))];
        end
        return word;
    endfunction

    function automatic accessLen randLen();
        case ($urandom % 3)
            0: return lenByte;
            1: return lenHalf;
            default: return lenWord;
        endcase
    endfunction

    task automatic startData(input memOp op, input accessLen len,
                             input logic [AddrWidth-1:0] addr,
                             input logic [DataWidth-1:0] wdata);
        dataEn    <= 1'b1;
        dataOp    <= op;
        dataLen   <= len;
        dataAddr  <= addr;
        dataWdata <= wdata;
        firstReq = 1'b1;
        xferCount++;
        if (op == opStore) begin
            refWe   <= 1'b1;
            refAddr <= addr;
            refLen  <= len;
            refData <= wdata;
            expLoad = 1'b0;
            expLat  = int'(len) + 1;
        end else begin
            expLoad = 1'b1;
            expData = refWord(addr, int'(len));
            expLat  = int'(len) + 2;
        end
    endtask

    task automatic startFetch(input logic [AddrWidth-1:0] addr);
        fetchEn   <= 1'b1;
        fetchAddr <= addr;
        firstReq = 1'b1;
        xferCount++;
        expInst = refWord(addr, FetchBytes);
        expLat  = FetchBytes + 2;
    endtask

    // each enable drops on the edge that sees its done strobe
    task automatic waitDone(input logic wantData, input logic wantFetch);
        logic pendData;
        logic pendFetch;
        pendData  = wantData;
        pendFetch = wantFetch;
        while (pendData || pendFetch) begin
            tick();
            if (pendData && dataDone) begin
                dataEn <= 1'b0;
                pendData = 1'b0;
            end
            if (pendFetch && fetchDone) begin
                fetchEn <= 1'b0;
                pendFetch = 1'b0;
            end
        end
    endtask

    task automatic runData(input memOp op, input accessLen len,
                           input logic [AddrWidth-1:0] addr);
        tick();
        startData(op, len, addr, $urandom);
        waitDone(1'b1, 1'b0);
    endtask

    task automatic runFetch(input logic [AddrWidth-1:0] addr);
        tick();
        startFetch(addr);
        waitDone(1'b0, 1'b1);
    endtask

    task automatic runPair(input logic [AddrWidth-1:0] dAddr,
                           input logic [AddrWidth-1:0] fAddr);
        tick();
        startData(opLoad, lenWord, dAddr, '0);
        startFetch(fAddr);
        waitDone(1'b1, 1'b1);
    endtask

    task automatic endTest(input string name, input int xfers);
        tick();
        testCount++;
        $display("test %-6s %0d transfers, %0d errors", name, xfers, errCount - errMark);
        errMark = errCount;
    endtask

    initial begin
        accessLen             lens [3];
        logic [AddrWidth-1:0] addr;
        lens = '{lenByte, lenHalf, lenWord};
        void'($urandom(17134));
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataOp       = opLoad;
        dataLen      = lenByte;
        dataAddr     = '0;
        dataWdata    = '0;
        refWe        = 1'b0;
        refAddr      = '0;
        refLen       = '0;
        refData      = '0;
        repeat (5) tick();
        rst <= 1'b0;

        // idle outputs, no request yet
        repeat (4) tick();
        endTest("reset", 0);

        for (int i = 0; i < NumFetch; i++) begin
            runFetch($urandom);
        end
        endTest("fetch", NumFetch);

        for (int n = 0; n < 3; n++) begin
            for (int i = 0; i < LoadsPerLen; i++) begin
                runData(opLoad, lens[n], $urandom);
            end
        end
        endTest("load", 3 * LoadsPerLen);

        // each store is read back at once
        for (int n = 0; n < 3; n++) begin
            addr = $urandom;
            runData(opStore, lens[n], addr);
            runData(opLoad, lens[n], addr);
        end
        endTest("store", 6);

        timed = 1'b0;
        for (int i = 0; i < 2; i++) begin
            runPair($urandom, $urandom);
        end
        endTest("pair", 4);

        holdRun = 1'b1;
        for (int i = 0; i < NumHold; i++) begin
            addr = $urandom;
            case ($urandom % 3)
                0: runFetch(addr);
                1: runData(opLoad, randLen(), addr);
                default: runData(opStore, randLen(), addr);
            endcase
        end
        holdRun = 1'b0;
        endTest("hold", NumHold);

        $display("%0d tests, %0d transfers, %0d errors", testCount, xferCount, errCount);
        if (errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("timeout after %0d cycles, a done strobe never arrived", TimeoutCycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tbRamModel.sv */
`timescale 1ns/10ps
`default_nettype none

module tbRamModel #(
    parameter int AddrWidth = 32,
    parameter int DepthBits = 8
) (
    input  logic                 clk,
    input  logic [AddrWidth-1:0] memAddr,
    input  logic                 memWr,
    input  logic [7:0]           memDout,
    output logic [7:0]           memDin,
    // expected image, written by the testbench
    input  logic                 refWe,
    input  logic [AddrWidth-1:0] refAddr,
    input  logic [2:0]           refLen,
    input  logic [31:0]          refData,
    output int                   diffCount
);
    localparam int Depth = 1 << DepthBits;

    logic [7:0] mem    [Depth];
    logic [7:0] refMem [Depth];

    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i]    = 8'(i * 29 + 90);
            refMem[i] = 8'(i * 29 + 90);
        end
        memDin = '0;
    end

    // addresses wrap on the low bits, one cycle read latency
    always @(posedge clk) begin
        memDin <= mem[memAddr[DepthBits-1:0]];
        if (memWr) begin
            mem[memAddr[DepthBits-1:0]] <= memDout;
        end
    end

    // store lanes little-endian from the low address up
    always @(posedge clk) begin
        if (refWe) begin
            for (int k = 0; k < int'(refLen); k++) begin
                refMem[DepthBits'(refAddr + AddrWidth'(k))] <= refData[8*k +: 8];
            end
        end
    end

    // bytes where the RAM differs from the expected image
    always_comb begin
        diffCount = 0;
        for (int i = 0; i < Depth; i++) begin
            if (mem[i] !== refMem[i]) begin
                diffCount++;
            end
        end
    end

endmodule

`default_nettype wire
